// ==== hw/pce_bridge_pkg.sv ====
/*
  PC Engine bridge definitions
  register addresses of the settings map, the core setting fields and
  the analog adapter settings word with its decoded view
*/
package pce_bridge_pkg;

  //////////////////////////////////////////////////////////////////////
  // bridge register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [31:0] addr_cart_download = 32'h0000_0000;
  localparam logic [31:0] addr_save_download = 32'h0000_0004;
  localparam logic [31:0] addr_sgx           = 32'h0000_0008;
  localparam logic [31:0] addr_reset         = 32'h0000_0050;

  // controller options
  localparam logic [31:0] addr_turbo_tap     = 32'h0000_0100;
  localparam logic [31:0] addr_button6       = 32'h0000_0104;
  localparam logic [31:0] addr_turbo1        = 32'h0000_0108;
  localparam logic [31:0] addr_turbo2        = 32'h0000_010C;

  // video options
  localparam logic [31:0] addr_overscan      = 32'h0000_0200;
  localparam logic [31:0] addr_extra_sprites = 32'h0000_0204;
  localparam logic [31:0] addr_raw_rgb       = 32'h0000_0208;

  // audio mix
  localparam logic [31:0] addr_master_boost  = 32'h0000_0300;
  localparam logic [31:0] addr_adpcm_boost   = 32'h0000_0304;
  localparam logic [31:0] addr_cd_boost      = 32'h0000_0308;

  localparam logic [31:0] addr_chroma_add    = 32'h0000_0400;
  localparam logic [31:0] addr_chroma_mult   = 32'h0000_0410;

  // analog adapter settings, also readable
  localparam logic [31:0] addr_analogizer    = 32'hF700_0000;

  //////////////////////////////////////////////////////////////////////
  // setting types
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       cart_download;
    logic       save_download;
    logic       sgx;
    logic       turbo_tap;
    logic       button6;
    logic [1:0] turbo1_speed;
    logic [1:0] turbo2_speed;
    logic       overscan;
    logic       extra_sprites;
    logic       raw_rgb;
    logic [1:0] master_boost;
    logic       adpcm_boost;
    logic       cd_boost;
    logic [4:0] chroma_add;
    logic [4:0] chroma_mult;
  } pce_settings_t;

  typedef struct packed {
    logic [3:0] video_type;
    logic [3:0] cont_assign;
    logic       unused;
    logic [4:0] game_cont_type;
  } analogizer_fields_t;

  // raw view for the bridge, field view for the decoders
  typedef union packed {
    logic [13:0]        raw;
    analogizer_fields_t fields;
  } analogizer_word_u;

endpackage

// ==== hw/pce_input_pkg.sv ====
/*
  PC Engine input and video definitions
  controller key bitmap, the four-player key array and the video
  bundles on both sides of the analog capture stage
*/
package pce_input_pkg;

  // handheld and adapter controllers share this bitmap
  typedef struct packed {
    logic start;
    logic select;
    logic r3;
    logic l3;
    logic r2;
    logic l2;
    logic r1;
    logic l1;
    logic y;
    logic x;
    logic b;
    logic a;
    logic right;
    logic left;
    logic down;
    logic up;
  } cont_key_t;

  // index 0 is player 1
  typedef cont_key_t [3:0] player_keys_t;

  //////////////////////////////////////////////////////////////////////
  // video bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        ce_pix;
    logic        hblank;
    logic        vblank;
    logic        hsync;
    logic        vsync;
    logic [23:0] rgb;
  } core_video_t;

  typedef struct packed {
    logic        csync;
    logic        de;
    logic        vsync;
    logic [23:0] rgb;
  } analog_video_t;

  // adapter video types that run PAL timing
  localparam logic [3:0] video_type_pal_a = 4'h4;
  localparam logic [3:0] video_type_pal_b = 4'hC;

  // video type bit that turns the handheld screen black
  localparam int unsigned video_type_blank_bit = 3;

endpackage

// ==== hw/pce_setting_regs.sv ====
/*
  PC Engine setting registers
  decodes bridge writes into core settings and the adapter word,
  holds the core in reset for a fixed time after a reset write and
  returns the adapter word on bridge reads
*/
module pce_setting_regs
  import pce_bridge_pkg::*;
#(
  parameter logic [31:0] RESET_HOLD = 32'h0010_0000
) (
  input  logic             clk_74a,
  input  logic             pll_core_locked,
  input  logic [31:0]      bridge_addr,
  input  logic             bridge_wr,
  input  logic [31:0]      bridge_wr_data,
  output logic [31:0]      bridge_rd_data,
  output pce_settings_t    settings,
  output analogizer_word_u analogizer,
  output logic             core_reset
);

  logic [31:0] reset_count;

  //////////////////////////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////////////////////////

  // only the low bits each field needs are kept
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings   <= '0;
      analogizer <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        addr_cart_download: settings.cart_download <= bridge_wr_data[0];
        addr_save_download: settings.save_download <= bridge_wr_data[0];
        addr_sgx:           settings.sgx           <= bridge_wr_data[0];
        addr_turbo_tap:     settings.turbo_tap     <= bridge_wr_data[0];
        addr_button6:       settings.button6       <= bridge_wr_data[0];
        addr_turbo1:        settings.turbo1_speed  <= bridge_wr_data[1:0];
        addr_turbo2:        settings.turbo2_speed  <= bridge_wr_data[1:0];
        addr_overscan:      settings.overscan      <= bridge_wr_data[0];
        addr_extra_sprites: settings.extra_sprites <= bridge_wr_data[0];
        addr_raw_rgb:       settings.raw_rgb       <= bridge_wr_data[0];
        addr_master_boost:  settings.master_boost  <= bridge_wr_data[1:0];
        addr_adpcm_boost:   settings.adpcm_boost   <= bridge_wr_data[0];
        addr_cd_boost:      settings.cd_boost      <= bridge_wr_data[0];
        addr_chroma_add:    settings.chroma_add    <= bridge_wr_data[4:0];
        addr_chroma_mult:   settings.chroma_mult   <= bridge_wr_data[4:0];
        addr_analogizer:    analogizer.raw         <= bridge_wr_data[13:0];
        default: begin
          // unmapped address, nothing stored
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reset hold
  //////////////////////////////////////////////////////////////////////

  // a reset write reloads, even while already counting
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_count <= '0;
    end else if (bridge_wr && (bridge_addr == addr_reset)) begin
      reset_count <= RESET_HOLD;
    end else if (reset_count != '0) begin
      reset_count <= reset_count - 32'd1;
    end
  end

  assign core_reset = (reset_count != '0);

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (bridge_addr == addr_analogizer) begin
      bridge_rd_data = {18'h0, analogizer.raw};
    end else begin
      bridge_rd_data = '0;
    end
  end

endmodule

// ==== hw/snac_player_router.sv ====
/*
  SNAC player router
  picks handheld or adapter controllers for each of the four players
  from the adapter assignment code, one register stage
*/
module snac_player_router
  import pce_bridge_pkg::*;
  import pce_input_pkg::*;
(
  input  logic             clk_74a,
  input  logic             pll_core_locked,
  input  player_keys_t     cont_keys,
  input  player_keys_t     snac_keys,
  input  analogizer_word_u analogizer,
  output player_keys_t     players
);

  player_keys_t players_next;

  // game type zero means the adapter controllers are off
  always_comb begin
    players_next = cont_keys;
    if (analogizer.fields.game_cont_type != 5'd0) begin
      case (analogizer.fields.cont_assign)
        4'h0: players_next[0] = snac_keys[0];
        4'h1: players_next[1] = snac_keys[0];
        4'h2: begin
          players_next[0] = snac_keys[0];
          players_next[1] = snac_keys[1];
        end
        4'h3: begin
          players_next[0] = snac_keys[1];
          players_next[1] = snac_keys[0];
        end
        4'h4: players_next = snac_keys;
        // reversed order
        4'h5: begin
          players_next[0] = snac_keys[3];
          players_next[1] = snac_keys[2];
          players_next[2] = snac_keys[1];
          players_next[3] = snac_keys[0];
        end
        // multitap, adapter pads on players 3 and 4
        4'h6: begin
          players_next[2] = snac_keys[0];
          players_next[3] = snac_keys[1];
        end
        default: players_next = cont_keys;
      endcase
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      players <= '0;
    end else begin
      players <= players_next;
    end
  end

endmodule

// ==== hw/analog_video_prep.sv ====
/*
  Analog video prep
  samples core video on each rising pixel enable and derives composite
  sync, display enable, the handheld screen colour and the PAL flag
*/
module analog_video_prep
  import pce_bridge_pkg::*;
  import pce_input_pkg::*;
(
  input  logic             clk_74a,
  input  logic             pll_core_locked,
  input  core_video_t      core_video,
  input  analogizer_word_u analogizer,
  output analog_video_t    analog_video,
  output logic [23:0]      pocket_rgb,
  output logic             pal_flag
);

  logic       ce_pix_prev;
  logic       pix_rise;
  logic [3:0] video_type;

  assign video_type = analogizer.fields.video_type;

  // ce_pix high now, low at the previous edge
  assign pix_rise = core_video.ce_pix && !ce_pix_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ce_pix_prev <= 1'b0;
    end else begin
      ce_pix_prev <= core_video.ce_pix;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pixel capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      analog_video <= '0;
      pocket_rgb   <= '0;
    end else if (pix_rise) begin
      // sync is high when hsync and vsync agree
      analog_video.csync <= ~(core_video.hsync ^ core_video.vsync);
      analog_video.de    <= ~(core_video.hblank | core_video.vblank);
      analog_video.vsync <= core_video.vsync;
      analog_video.rgb   <= core_video.rgb;
      // handheld screen goes black while the adapter drives a display
      if (video_type[video_type_blank_bit]) begin
        pocket_rgb <= 24'h00_0000;
      end else begin
        pocket_rgb <= core_video.rgb;
      end
    end
  end

  assign pal_flag = (video_type == video_type_pal_a) || (video_type == video_type_pal_b);

endmodule

// ==== hw/pce_core_top.sv ====
/*
  PC Engine core shell
  settings registers, controller routing and analog video capture
  around the console core, all on the bridge clock
*/
module pce_core_top
  import pce_bridge_pkg::*;
  import pce_input_pkg::*;
#(
  parameter logic [31:0] RESET_HOLD = 32'h0010_0000
) (
  input  logic          clk_74a,
  input  logic          pll_core_locked,
  // bridge
  input  logic [31:0]   bridge_addr,
  input  logic          bridge_wr,
  input  logic [31:0]   bridge_wr_data,
  output logic [31:0]   bridge_rd_data,
  // controllers
  input  player_keys_t  cont_keys,
  input  player_keys_t  snac_keys,
  // core video in
  input  core_video_t   core_video,
  // to the console core
  output pce_settings_t settings,
  output logic          core_reset,
  output player_keys_t  players,
  // video out
  output analog_video_t analog_video,
  output logic [23:0]   pocket_rgb,
  output logic          pal_flag
);

  analogizer_word_u analogizer;

  pce_setting_regs #(
    .RESET_HOLD(RESET_HOLD)
  ) i_pce_setting_regs (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings),
    .analogizer     (analogizer),
    .core_reset     (core_reset)
  );

  snac_player_router i_snac_player_router (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cont_keys      (cont_keys),
    .snac_keys      (snac_keys),
    .analogizer     (analogizer),
    .players        (players)
  );

  analog_video_prep i_analog_video_prep (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .core_video     (core_video),
    .analogizer     (analogizer),
    .analog_video   (analog_video),
    .pocket_rgb     (pocket_rgb),
    .pal_flag       (pal_flag)
  );

endmodule

// ==== sim/pce_core_chk.sv ====
/*
  PC Engine core shell checker
  concurrent properties on the readback width, reset and PAL flag
*/
module pce_core_chk
  import pce_bridge_pkg::*;
(
  input logic             clk_74a,
  input logic             pll_core_locked,
  input logic [31:0]      bridge_rd_data,
  input logic             core_reset,
  input logic             pal_flag,
  input analogizer_word_u analogizer
);

  logic [3:0] video_type;

  assign video_type = analogizer.fields.video_type;

  // adapter word is only 14 bits wide
  rd_upper_zero: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    bridge_rd_data[31:14] == 18'h0)
    else $error("bridge read data has bits set above the adapter word");

  reset_low_unlocked: assert property (@(posedge clk_74a)
    !pll_core_locked |-> !core_reset)
    else $error("core reset is high while the PLL is not locked");

  // types 4 and 12 run PAL timing
  pal_matches_type: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    pal_flag == ((video_type == 4'h4) || (video_type == 4'hC)))
    else $error("PAL flag does not match the adapter video type");

endmodule

bind pce_core_top pce_core_chk i_pce_core_chk (
  .clk_74a        (clk_74a),
  .pll_core_locked(pll_core_locked),
  .bridge_rd_data (bridge_rd_data),
  .core_reset     (core_reset),
  .pal_flag       (pal_flag),
  .analogizer     (analogizer)
);

// ==== sim/tb_pce_core_top.sv ====
/*
  PC Engine core shell testbench
  runs a table of bridge writes, reads, controller routing, reset hold
  and video capture rows against the shell and checks each response
*/
module tb_pce_core_top
  import pce_bridge_pkg::*;
  import pce_input_pkg::*;
();

  localparam logic [2:0] op_write = 3'd0;
  localparam logic [2:0] op_read  = 3'd1;
  localparam logic [2:0] op_route = 3'd2;
  localparam logic [2:0] op_video = 3'd3;
  localparam logic [2:0] op_reset = 3'd4;

  typedef struct packed {
    logic [2:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    core_video_t video;
    logic [63:0] want;
  } row_t;

  logic          clk_74a = 1'b0;
  logic          pll_core_locked;
  logic [31:0]   bridge_addr;
  logic          bridge_wr;
  logic [31:0]   bridge_wr_data;
  logic [31:0]   bridge_rd_data;
  player_keys_t  cont_keys;
  player_keys_t  snac_keys;
  core_video_t   core_video;
  pce_settings_t settings;
  logic          core_reset;
  player_keys_t  players;
  analog_video_t analog_video;
  logic [23:0]   pocket_rgb;
  logic          pal_flag;

  row_t          rows[$];
  pce_settings_t exp_settings = '0;
  integer        seed = 32'h41e6_aecb;
  int            cycles = 0;
  int            limit = 0;

  pce_core_top #(
    .RESET_HOLD(32'd16)
  ) i_pce_core_top (.*);

  always #2 clk_74a = ~clk_74a;

  // run limit sized from the table once it is built
  always @(posedge clk_74a) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run went past %0d cycles without finishing", limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] want,
                             input logic [63:0] got);
    assert (got === want) else begin
      $display("CHECK FAILED time %0t signal %s expected %0h actual %0h",
               $time, name, want, got);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic add_row(input logic [2:0] op, input logic [31:0] addr,
                         input logic [31:0] data, input core_video_t video,
                         input logic [63:0] want);
    rows.push_back(row_t'{op, addr, data, video, want});
  endtask

  // settings after a write with the value already masked in the table
  function automatic pce_settings_t with_field(pce_settings_t s, logic [31:0] addr,
                                               logic [63:0] v);
    case (addr)
      addr_cart_download: s.cart_download = v[0];
      addr_save_download: s.save_download = v[0];
      addr_sgx:           s.sgx           = v[0];
      addr_turbo_tap:     s.turbo_tap     = v[0];
      addr_button6:       s.button6       = v[0];
      addr_turbo1:        s.turbo1_speed  = v[1:0];
      addr_turbo2:        s.turbo2_speed  = v[1:0];
      addr_overscan:      s.overscan      = v[0];
      addr_extra_sprites: s.extra_sprites = v[0];
      addr_raw_rgb:       s.raw_rgb       = v[0];
      addr_master_boost:  s.master_boost  = v[1:0];
      addr_adpcm_boost:   s.adpcm_boost   = v[0];
      addr_cd_boost:      s.cd_boost      = v[0];
      addr_chroma_add:    s.chroma_add    = v[4:0];
      addr_chroma_mult:   s.chroma_mult   = v[4:0];
      default: begin
        // no settings field at this address
      end
    endcase
    return s;
  endfunction

  // one nibble per player where bit 3 picks the adapter pad and bits 1:0 its number
  function automatic player_keys_t pick_players(player_keys_t c, player_keys_t s,
                                                logic [15:0] src);
    player_keys_t r;
    logic [3:0]   code;
    for (int p = 0; p < 4; p++) begin
      code = src[4*p +: 4];
      r[p] = code[3] ? s[code[1:0]] : c[code[1:0]];
    end
    return r;
  endfunction

  task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
    @(posedge clk_74a);
    bridge_addr    <= a;
    bridge_wr      <= 1'b1;
    bridge_wr_data <= d;
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // adapter word straight after reset
    add_row(op_read, addr_analogizer, 32'h0, '0, 64'h0);
    add_row(op_write, addr_cart_download, 32'h0000_0003, '0, 64'h1);
    add_row(op_write, addr_save_download, 32'h0000_0007, '0, 64'h1);
    add_row(op_write, addr_sgx, 32'hFFFF_FFFE, '0, 64'h0);
    add_row(op_write, addr_sgx, 32'h0000_0001, '0, 64'h1);
    add_row(op_write, addr_turbo_tap, 32'h8000_0001, '0, 64'h1);
    add_row(op_write, addr_button6, 32'h0000_0003, '0, 64'h1);
    add_row(op_write, addr_turbo1, 32'hFFFF_FFFF, '0, 64'h3);
    add_row(op_write, addr_turbo2, 32'h0000_0006, '0, 64'h2);
    add_row(op_write, addr_overscan, 32'h0000_00FF, '0, 64'h1);
    add_row(op_write, addr_extra_sprites, 32'h0000_0005, '0, 64'h1);
    add_row(op_write, addr_raw_rgb, 32'h0000_0003, '0, 64'h1);
    add_row(op_write, addr_master_boost, 32'h0000_000D, '0, 64'h1);
    add_row(op_write, addr_adpcm_boost, 32'h0000_0011, '0, 64'h1);
    add_row(op_write, addr_cd_boost, 32'h0000_0008, '0, 64'h0);
    add_row(op_write, addr_cd_boost, 32'hFFFF_FFFF, '0, 64'h1);
    add_row(op_write, addr_chroma_add, 32'h0000_0036, '0, 64'h16);
    add_row(op_write, addr_chroma_mult, 32'h0000_00FF, '0, 64'h1F);
    // unmapped addresses
    add_row(op_write, 32'h0000_0210, 32'hFFFF_FFFF, '0, 64'h0);
    add_row(op_write, 32'h0000_0404, 32'hFFFF_FFFF, '0, 64'h0);
    add_row(op_write, addr_analogizer, 32'hFFFF_EA5F, '0, 64'h0);
    add_row(op_read, addr_analogizer, 32'h0, '0, 64'h2A5F);
    add_row(op_read, addr_sgx, 32'h0, '0, 64'h0);
    add_row(op_read, 32'hF700_0004, 32'h0, '0, 64'h0);
    // routing for game type zero then assign codes 0 to 7
    add_row(op_route, addr_analogizer, 32'h0000_0100, '0, 64'h3210);
    add_row(op_route, addr_analogizer, 32'h0000_0001, '0, 64'h3218);
    add_row(op_route, addr_analogizer, 32'h0000_0041, '0, 64'h3280);
    add_row(op_route, addr_analogizer, 32'h0000_0081, '0, 64'h3298);
    add_row(op_route, addr_analogizer, 32'h0000_00C1, '0, 64'h3289);
    add_row(op_route, addr_analogizer, 32'h0000_0101, '0, 64'hBA98);
    add_row(op_route, addr_analogizer, 32'h0000_0141, '0, 64'h89AB);
    add_row(op_route, addr_analogizer, 32'h0000_0181, '0, 64'h9810);
    add_row(op_route, addr_analogizer, 32'h0000_01C1, '0, 64'h3210);
    add_row(op_reset, addr_reset, 32'h0000_0001, '0, 64'd16);
    // video rows with want as {pal_flag, pocket_rgb, csync, de, vsync, rgb}
    add_row(op_video, addr_analogizer, 32'h0000_0000, {1'b0, 4'b0000, 24'h123456},
            64'({1'b0, 24'h123456, 3'b110, 24'h123456}));
    add_row(op_video, addr_analogizer, 32'h0000_1000, {1'b0, 4'b1010, 24'hA0B0C0},
            64'({1'b1, 24'hA0B0C0, 3'b000, 24'hA0B0C0}));
    add_row(op_video, addr_analogizer, 32'h0000_3000, {1'b0, 4'b0111, 24'hFF8001},
            64'({1'b1, 24'h000000, 3'b101, 24'hFF8001}));
    add_row(op_video, addr_analogizer, 32'h0000_2000, {1'b0, 4'b0001, 24'h00FF7F},
            64'({1'b0, 24'h000000, 3'b011, 24'h00FF7F}));
  endtask

  task automatic run_row(input row_t r);
    player_keys_t c;
    player_keys_t s;
    core_video_t  v;
    int           hold;
    case (r.op)
      op_write: begin
        bus_write(r.addr, r.data);
        exp_settings = with_field(exp_settings, r.addr, r.want);
        @(negedge clk_74a);
        check_value("settings", 64'(exp_settings), 64'(settings));
      end
      op_read: begin
        @(posedge clk_74a);
        bridge_addr <= r.addr;
        @(negedge clk_74a);
        check_value("bridge_rd_data", r.want, 64'(bridge_rd_data));
      end
      op_route: begin
        bus_write(r.addr, r.data);
        for (int p = 0; p < 4; p++) begin
          c[p] = 16'($random(seed));
          s[p] = 16'($random(seed));
        end
        @(posedge clk_74a);
        cont_keys <= c;
        snac_keys <= s;
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_value("players", 64'(pick_players(c, s, r.want[15:0])), 64'(players));
      end
      op_reset: begin
        bus_write(r.addr, r.data);
        hold = 0;
        @(negedge clk_74a);
        while (core_reset && hold < 64) begin
          hold++;
          @(negedge clk_74a);
        end
        check_value("core_reset high cycles", r.want, 64'(hold));
      end
      default: begin
        bus_write(r.addr, r.data);
        v = r.video;
        v.ce_pix = 1'b0;
        @(posedge clk_74a);
        core_video <= v;
        v.ce_pix = 1'b1;
        @(posedge clk_74a);
        core_video <= v;
        // capture edge then change the inputs with ce_pix still high
        @(posedge clk_74a);
        v.rgb    = ~v.rgb;
        v.hsync  = ~v.hsync;
        v.hblank = ~v.hblank;
        core_video <= v;
        repeat (2) begin
          @(negedge clk_74a);
          check_value("pal_flag, pocket_rgb, analog_video", r.want,
                      64'({pal_flag, pocket_rgb, analog_video}));
          @(posedge clk_74a);
        end
        v.ce_pix = 1'b0;
        core_video <= v;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin
    pll_core_locked <= 1'b0;
    bridge_addr     <= '0;
    bridge_wr       <= 1'b0;
    bridge_wr_data  <= '0;
    cont_keys       <= '0;
    snac_keys       <= '0;
    core_video      <= '0;
    build_table();
    limit = rows.size() * 40;
    repeat (10) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    @(negedge clk_74a);
    check_value("core_reset", 64'h0, 64'(core_reset));
    check_value("settings", 64'h0, 64'(settings));
    check_value("players", 64'h0, 64'(players));
    check_value("analog_video", 64'h0, 64'(analog_video));
    check_value("pocket_rgb", 64'h0, 64'(pocket_rgb));
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
hw/pce_bridge_pkg.sv
hw/pce_input_pkg.sv
hw/pce_setting_regs.sv
hw/snac_player_router.sv
hw/analog_video_prep.sv
hw/pce_core_top.sv
sim/pce_core_chk.sv
sim/tb_pce_core_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_pce_core_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output="$(./obj_dir/tb_sim)"
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi
